/* source/riscv_pkg.sv */
package riscv_pkg;

  // major opcodes, bits [6:0] of the word
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 values, alu and immediate forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 values, memory and branch forms
  localparam logic [2:0] F3_WORD = 3'b010;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

  // funct7 values for register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ebreak is a single fixed word
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLT,
    ALU_EQ,
    ALU_NE
  } alu_op_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        use_pc_operand;
    logic        is_lui;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        is_jal;
    logic        reg_write;
    logic        is_ebreak;
    logic        illegal;
  } decoded_t;

endpackage

/* source/bus_pkg.sv */
package bus_pkg;

  // one request on the shared memory bus
  // addr counts 32-bit words, not bytes
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // one finished instruction, for the trace port
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        reg_write;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

endpackage

/* source/decoder.sv */
`timescale 1ns/100ps

module decoder import riscv_pkg::*; (
  input  logic [31:0] inst,
  output decoded_t    dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // sign-extended immediates, one per format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = inst[11:7];
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];
    dec.alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: begin
        // zero + imm through the adder
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.is_lui    = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm            = imm_u;
        dec.use_imm        = 1'b1;
        dec.use_pc_operand = 1'b1;
        dec.reg_write      = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          F3_ADD:  dec.alu_op = ALU_ADD;
          F3_SLT:  dec.alu_op = ALU_SLT;
          F3_XOR:  dec.alu_op = ALU_XOR;
          F3_OR:   dec.alu_op = ALU_OR;
          F3_AND:  dec.alu_op = ALU_AND;
          // shifts and sltiu not supported
          default: dec.illegal = 1'b1;
        endcase
      end
      OPC_OP: begin
        dec.reg_write = 1'b1;
        if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          dec.alu_op = ALU_SUB;
        end else if (funct7 != F7_BASE) begin
          dec.illegal = 1'b1;
        end else begin
          case (funct3)
            F3_ADD:  dec.alu_op = ALU_ADD;
            F3_SLT:  dec.alu_op = ALU_SLT;
            F3_XOR:  dec.alu_op = ALU_XOR;
            F3_OR:   dec.alu_op = ALU_OR;
            F3_AND:  dec.alu_op = ALU_AND;
            default: dec.illegal = 1'b1;
          endcase
        end
      end
      OPC_LOAD: begin
        // lw only, address is rs1 + imm
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.is_load   = 1'b1;
        dec.reg_write = 1'b1;
        dec.illegal   = (funct3 != F3_WORD);
      end
      OPC_STORE: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
        dec.illegal  = (funct3 != F3_WORD);
      end
      OPC_JAL: begin
        dec.imm            = imm_j;
        dec.use_imm        = 1'b1;
        dec.use_pc_operand = 1'b1;
        dec.is_jal         = 1'b1;
        dec.reg_write      = 1'b1;
      end
      OPC_BRANCH: begin
        // rs1 vs rs2 compare, target built in the sequencer
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        case (funct3)
          F3_BEQ:  dec.alu_op = ALU_EQ;
          F3_BNE:  dec.alu_op = ALU_NE;
          default: dec.illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        dec.is_ebreak = (inst == EBREAK_WORD);
        dec.illegal   = (inst != EBREAK_WORD);
      end
      default: dec.illegal = 1'b1;
    endcase
    // an illegal word must not touch state
    if (dec.illegal) begin
      dec.reg_write = 1'b0;
      dec.is_load   = 1'b0;
      dec.is_store  = 1'b0;
      dec.is_branch = 1'b0;
      dec.is_jal    = 1'b0;
    end
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        wen,
  input  logic [4:0]  rd,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  // x0 never written, so it reads back zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational read ports
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu import riscv_pkg::*; (
  input  alu_op_t     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        cond
);

  logic equal;

  assign equal = (a == b);

  // branch condition, low for non-branch ops
  always_comb begin
    case (op)
      ALU_EQ:  cond = equal;
      ALU_NE:  cond = !equal;
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_XOR: result = a ^ b;
      ALU_OR:  result = a | b;
      ALU_AND: result = a & b;
      // signed compare
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      default: result = {31'b0, cond};
    endcase
  end

endmodule

/* source/sequencer.sv */
`timescale 1ns/100ps

module sequencer import riscv_pkg::*, bus_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,
  output mem_req_t    fetch_req,
  input  logic [31:0] fetch_rdata,
  input  logic        fetch_rvalid,
  input  decoded_t    dec,
  input  logic        branch_taken,
  input  logic        lsu_done,
  output logic [31:0] inst,
  output logic [31:0] pc,
  output logic        exec,
  output logic        retire_strobe,
  output logic        halt,
  output logic        illegal
);

  typedef enum logic [2:0] {
    PH_FETCH,
    PH_WAIT,
    PH_EXEC,
    PH_MEMWAIT,
    PH_HALT
  } phase_t;

  phase_t      phase_q;
  logic        illegal_q;
  logic        stop;
  logic [31:0] next_pc;

  // ebreak or bad word ends the run
  assign stop = dec.is_ebreak | dec.illegal;

  // jal and taken branch both use pc + imm
  assign next_pc = (dec.is_jal || (dec.is_branch && branch_taken)) ? pc + dec.imm : pc + 32'd4;

  // loads retire in memwait, all others in exec
  assign retire_strobe = (phase_q == PH_EXEC && !stop && !dec.is_load &&
                          (!dec.is_store || lsu_done)) ||
                         (phase_q == PH_MEMWAIT && lsu_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q   <= PH_FETCH;
      pc        <= RESET_PC;
      illegal_q <= 1'b0;
    end else begin
      case (phase_q)
        PH_FETCH: phase_q <= PH_WAIT;
        PH_WAIT: begin
          if (fetch_rvalid) begin
            phase_q <= PH_EXEC;
          end
        end
        PH_EXEC: begin
          if (stop) begin
            phase_q   <= PH_HALT;
            illegal_q <= dec.illegal;
          end else if (dec.is_load) begin
            phase_q <= PH_MEMWAIT;
          end else if (retire_strobe) begin
            phase_q <= PH_FETCH;
            pc      <= next_pc;
          end
        end
        PH_MEMWAIT: begin
          if (retire_strobe) begin
            phase_q <= PH_FETCH;
            pc      <= next_pc;
          end
        end
        // stays here until reset
        default: phase_q <= PH_HALT;
      endcase
    end
  end

  // instruction latch
  always_ff @(posedge clk) begin
    if (phase_q == PH_WAIT && fetch_rvalid) begin
      inst <= fetch_rdata;
    end
  end

  // word-addressed read at pc
  assign fetch_req.valid = (phase_q == PH_FETCH);
  assign fetch_req.we    = 1'b0;
  assign fetch_req.addr  = {2'b00, pc[31:2]};
  assign fetch_req.wdata = '0;

  assign exec    = (phase_q == PH_EXEC);
  assign halt    = (phase_q == PH_HALT);
  assign illegal = illegal_q;

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit import bus_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        is_store,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output mem_req_t    lsu_req,
  input  logic [31:0] lsu_rdata,
  input  logic        lsu_rvalid,
  output logic [31:0] load_data,
  output logic        done
);

  logic        load_pending_q;
  logic [31:0] load_q;

  // one-cycle request, byte address turned into word address
  assign lsu_req.valid = start;
  assign lsu_req.we    = is_store;
  assign lsu_req.addr  = {2'b00, addr[31:2]};
  assign lsu_req.wdata = wdata;

  // a load waits one cycle for its data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_pending_q <= 1'b0;
    end else begin
      load_pending_q <= start & !is_store;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_rvalid) begin
      load_q <= lsu_rdata;
    end
  end

  // returned word shows through in the done cycle, then held
  assign load_data = lsu_rvalid ? lsu_rdata : load_q;

  // store completes right away
  assign done = (start & is_store) | load_pending_q;

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter import bus_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  mem_req_t    lsu_req,
  input  mem_req_t    fetch_req,
  output mem_req_t    mem_req,
  input  logic [31:0] mem_rdata,
  output logic [31:0] lsu_rdata,
  output logic [31:0] fetch_rdata,
  output logic        lsu_rvalid,
  output logic        fetch_rvalid
);

  logic rd_pending_q;
  logic rd_lsu_q;

  // lsu wins over fetch
  assign mem_req = lsu_req.valid ? lsu_req : fetch_req;

  // remember who owns the read in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pending_q <= 1'b0;
      rd_lsu_q     <= 1'b0;
    end else begin
      rd_pending_q <= mem_req.valid & !mem_req.we;
      rd_lsu_q     <= lsu_req.valid;
    end
  end

  assign lsu_rvalid   = rd_pending_q & rd_lsu_q;
  assign fetch_rvalid = rd_pending_q & !rd_lsu_q;

  // data only reaches the owner
  assign lsu_rdata   = lsu_rvalid ? mem_rdata : '0;
  assign fetch_rdata = fetch_rvalid ? mem_rdata : '0;

endmodule

/* source/core_top.sv */
`timescale 1ns/100ps

module core_top import riscv_pkg::*, bus_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,
  output mem_req_t    mem_req,
  input  logic [31:0] mem_rdata,
  output retire_t     retire,
  output logic        halt,
  output logic        illegal
);

  mem_req_t    fetch_req;
  mem_req_t    lsu_req;
  logic [31:0] fetch_rdata;
  logic [31:0] lsu_rdata;
  logic        fetch_rvalid;
  logic        lsu_rvalid;
  decoded_t    dec;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        exec;
  logic        retire_strobe;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_result;
  logic        alu_cond;
  logic        lsu_start;
  logic        lsu_done;
  logic [31:0] load_data;
  logic [31:0] wb_data;

  sequencer #(
    .RESET_PC (RESET_PC)
  ) sequencer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req     (fetch_req),
    .fetch_rdata   (fetch_rdata),
    .fetch_rvalid  (fetch_rvalid),
    .dec           (dec),
    .branch_taken  (alu_cond),
    .lsu_done      (lsu_done),
    .inst          (inst),
    .pc            (pc),
    .exec          (exec),
    .retire_strobe (retire_strobe),
    .halt          (halt),
    .illegal       (illegal)
  );

  decoder decoder_i (
    .inst (inst),
    .dec  (dec)
  );

  register_file register_file_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (dec.rs1),
    .rs2    (dec.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (retire_strobe & dec.reg_write),
    .rd     (dec.rd),
    .wdata  (wb_data)
  );

  // operand 1: pc for auipc/jal, zero for lui
  assign op_a = dec.use_pc_operand ? pc : (dec.is_lui ? '0 : rdata1);
  assign op_b = dec.use_imm ? dec.imm : rdata2;

  alu alu_i (
    .op     (dec.alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result),
    .cond   (alu_cond)
  );

  // memory ops start only in exec
  assign lsu_start = exec & (dec.is_load | dec.is_store);

  load_store_unit load_store_unit_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (lsu_start),
    .is_store   (dec.is_store),
    .addr       (alu_result),
    .wdata      (rdata2),
    .lsu_req    (lsu_req),
    .lsu_rdata  (lsu_rdata),
    .lsu_rvalid (lsu_rvalid),
    .load_data  (load_data),
    .done       (lsu_done)
  );

  mem_arbiter mem_arbiter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req      (lsu_req),
    .fetch_req    (fetch_req),
    .mem_req      (mem_req),
    .mem_rdata    (mem_rdata),
    .lsu_rdata    (lsu_rdata),
    .fetch_rdata  (fetch_rdata),
    .lsu_rvalid   (lsu_rvalid),
    .fetch_rvalid (fetch_rvalid)
  );

  // write-back select, jal links pc + 4
  assign wb_data = dec.is_load ? load_data : (dec.is_jal ? pc + 32'd4 : alu_result);

  // retire trace
  assign retire.valid     = retire_strobe;
  assign retire.pc        = pc;
  assign retire.reg_write = dec.reg_write;
  assign retire.rd        = dec.rd;
  assign retire.data      = wb_data;

endmodule

/* tests/core_checker.sv */
`timescale 1ns/100ps

module core_checker import bus_pkg::*; (
  input  logic     clk,
  input  retire_t  retire,
  input  mem_req_t mem_req,
  input  logic     halt,
  input  logic     illegal
);

  localparam int MAX_ROWS       = 64;
  localparam int RETIRE_TIMEOUT = 20;
  localparam int QUIET_CYCLES   = 10;

  // expected retire rows that the testbench fills before each run
  string       exp_name [MAX_ROWS];
  logic [31:0] exp_pc   [MAX_ROWS];
  logic        exp_rw   [MAX_ROWS];
  logic [4:0]  exp_rd   [MAX_ROWS];
  logic [31:0] exp_data [MAX_ROWS];
  int          n_exp  = 0;
  int          errors = 0;

  task automatic clear_rows();
    n_exp = 0;
  endtask

  task automatic add_row(input string name, input logic [31:0] pc, input logic rw,
                         input logic [4:0] rd, input logic [31:0] data);
    exp_name[n_exp] = name;
    exp_pc[n_exp]   = pc;
    exp_rw[n_exp]   = rw;
    exp_rd[n_exp]   = rd;
    exp_data[n_exp] = data;
    n_exp++;
  endtask

  task automatic compare_field(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
      errors++;
    end
  endtask

  // walks the rows and then waits for halt and a quiet period
  task automatic check_run(input logic want_illegal);
    retire_t got;
    logic    seen;
    logic    stopped;
    int      cycles;
    stopped = 1'b0;
    if (halt !== 1'b0 || illegal !== 1'b0) begin
      $display("halt or illegal is not low after reset");
      errors++;
    end
    for (int i = 0; i < n_exp && !stopped; i++) begin
      seen   = 1'b0;
      cycles = 0;
      while (!seen && !stopped && cycles < RETIRE_TIMEOUT) begin
        @(posedge clk);
        cycles++;
        if (retire.valid === 1'b1) begin
          seen = 1'b1;
          got  = retire;
        end else if (halt === 1'b1) begin
          $display("core halted before row %s retired", exp_name[i]);
          errors++;
          stopped = 1'b1;
        end
      end
      if (seen) begin
        compare_field(exp_name[i], "pc", exp_pc[i], got.pc);
        compare_field(exp_name[i], "reg_write", exp_rw[i], got.reg_write);
        // rd and data only mean something on a register write
        if (exp_rw[i]) begin
          compare_field(exp_name[i], "rd", exp_rd[i], got.rd);
          compare_field(exp_name[i], "data", exp_data[i], got.data);
        end
      end else if (!stopped) begin
        $display("row %s did not retire within %0d cycles", exp_name[i], RETIRE_TIMEOUT);
        errors++;
        stopped = 1'b1;
      end
    end
    // halt must follow the last row
    cycles = 0;
    while (halt !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (retire.valid === 1'b1) begin
        $display("unexpected retire at pc %h before halt", retire.pc);
        errors++;
      end
    end
    if (halt !== 1'b1) begin
      $display("halt was not raised within %0d cycles", RETIRE_TIMEOUT);
      errors++;
    end else begin
      compare_field("halt", "illegal", want_illegal, illegal);
      // nothing may move while halted
      for (int c = 0; c < QUIET_CYCLES; c++) begin
        @(posedge clk);
        if (retire.valid === 1'b1) begin
          $display("retire at pc %h seen after halt", retire.pc);
          errors++;
        end
        if (mem_req.valid === 1'b1) begin
          $display("memory request to word %h seen after halt", mem_req.addr);
          errors++;
        end
        if (halt !== 1'b1) begin
          $display("halt dropped before reset");
          errors++;
        end
      end
    end
  endtask

endmodule

/* tests/core_tb.sv */
`timescale 1ns/100ps

module core_tb import riscv_pkg::*, bus_pkg::*; ();

  localparam logic [31:0] RESET_PC  = 32'h0000_0040;
  localparam int          MEM_WORDS = 256;
  localparam int          MAX_ROWS  = 40;
  localparam logic [31:0] SEED      = 32'd37686;
  // byte address used by the sw/lw pair
  localparam logic [11:0] DATA_BASE = 12'h200;

  logic        clk;
  logic        rst_n;
  mem_req_t    mem_req;
  logic [31:0] mem_rdata;
  retire_t     retire;
  logic        halt;
  logic        illegal;

  logic [31:0] mem [MEM_WORDS];
  logic        rd_pending;
  int          rd_index;
  int          tb_errors;
  logic [31:0] seed;

  // program table with row i at RESET_PC + 4i
  string       row_name    [MAX_ROWS];
  logic [31:0] row_inst    [MAX_ROWS];
  logic        row_retires [MAX_ROWS];
  logic        row_rw      [MAX_ROWS];
  logic [4:0]  row_rd      [MAX_ROWS];
  logic [31:0] row_value   [MAX_ROWS];
  int          n_rows;
  // architectural registers as the ISA rules leave them
  logic [31:0] xr [32];

  core_top #(
    .RESET_PC (RESET_PC)
  ) core_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .retire    (retire),
    .halt      (halt),
    .illegal   (illegal)
  );

  core_checker core_checker_i (
    .clk     (clk),
    .retire  (retire),
    .mem_req (mem_req),
    .halt    (halt),
    .illegal (illegal)
  );

  always #10 clk = ~clk;

  // memory model returns read data one cycle after the strobe
  always @(negedge clk) begin
    mem_rdata  = rd_pending ? mem[rd_index] : 32'h0;
    rd_pending = 1'b0;
    if (mem_req.valid === 1'b1) begin
      if (mem_req.addr >= MEM_WORDS) begin
        $display("memory request to word %h is outside the memory model", mem_req.addr);
        tb_errors++;
      end else if (mem_req.we) begin
        mem[mem_req.addr] = mem_req.wdata;
      end else begin
        rd_pending = 1'b1;
        rd_index   = mem_req.addr;
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // one instruction word builder per format
  function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] stype_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] btype_word(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] next_row_pc();
    return RESET_PC + 4 * n_rows;
  endfunction

  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return $signed(a) < $signed(b);
  endfunction

  // append a row and apply its register effect
  task automatic put_row(input string name, input logic [31:0] word, input logic retires,
                         input logic rw, input logic [4:0] rd, input logic [31:0] value);
    row_name[n_rows]    = name;
    row_inst[n_rows]    = word;
    row_retires[n_rows] = retires;
    row_rw[n_rows]      = rw;
    row_rd[n_rows]      = rd;
    row_value[n_rows]   = value;
    n_rows++;
    if (retires && rw && rd != 5'd0) begin
      xr[rd] = value;
    end
  endtask

  task automatic clear_program();
    n_rows = 0;
    for (int r = 0; r < 32; r++) begin
      xr[r] = 32'h0;
    end
  endtask

  task automatic build_main_program();
    logic [11:0] imm_a;
    logic [11:0] imm_n;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    logic [19:0] imm_u;
    logic [19:0] imm_v;
    clear_program();
    seed  = xorshift(seed);
    imm_a = {1'b0, seed[10:0]};
    seed  = xorshift(seed);
    imm_n = {1'b1, seed[10:0]};
    seed  = xorshift(seed);
    imm_b = seed[11:0];
    imm_c = seed[23:12];
    seed  = xorshift(seed);
    imm_u = seed[19:0];
    imm_v = seed[31:12];
    // immediate alu forms
    put_row("addi_pos", itype_word(OPC_OP_IMM, F3_ADD, 1, 0, imm_a), 1, 1, 1, sext12(imm_a));
    put_row("addi_neg", itype_word(OPC_OP_IMM, F3_ADD, 2, 0, imm_n), 1, 1, 2, sext12(imm_n));
    put_row("xori", itype_word(OPC_OP_IMM, F3_XOR, 3, 1, imm_b), 1, 1, 3, xr[1] ^ sext12(imm_b));
    put_row("ori", itype_word(OPC_OP_IMM, F3_OR, 4, 2, imm_c), 1, 1, 4, xr[2] | sext12(imm_c));
    put_row("andi", itype_word(OPC_OP_IMM, F3_AND, 5, 1, imm_b), 1, 1, 5, xr[1] & sext12(imm_b));
    put_row("slti", itype_word(OPC_OP_IMM, F3_SLT, 6, 2, imm_a), 1, 1, 6,
            {31'b0, signed_less(xr[2], sext12(imm_a))});
    // register alu forms
    put_row("add", rtype_word(F7_BASE, F3_ADD, 7, 1, 2), 1, 1, 7, xr[1] + xr[2]);
    put_row("sub", rtype_word(F7_SUB, F3_ADD, 8, 1, 2), 1, 1, 8, xr[1] - xr[2]);
    put_row("xor", rtype_word(F7_BASE, F3_XOR, 9, 7, 8), 1, 1, 9, xr[7] ^ xr[8]);
    put_row("or", rtype_word(F7_BASE, F3_OR, 10, 3, 4), 1, 1, 10, xr[3] | xr[4]);
    put_row("and", rtype_word(F7_BASE, F3_AND, 11, 9, 10), 1, 1, 11, xr[9] & xr[10]);
    put_row("slt_neg_pos", rtype_word(F7_BASE, F3_SLT, 12, 2, 1), 1, 1, 12,
            {31'b0, signed_less(xr[2], xr[1])});
    put_row("slt_pos_neg", rtype_word(F7_BASE, F3_SLT, 13, 1, 2), 1, 1, 13,
            {31'b0, signed_less(xr[1], xr[2])});
    // x0 write retires with its value but keeps x0 at zero
    put_row("addi_x0", itype_word(OPC_OP_IMM, F3_ADD, 0, 1, 12'd5), 1, 1, 0, xr[1] + 32'd5);
    put_row("read_x0", rtype_word(F7_BASE, F3_ADD, 14, 0, 1), 1, 1, 14, xr[0] + xr[1]);
    put_row("lui", utype_word(OPC_LUI, 15, imm_u), 1, 1, 15, {imm_u, 12'b0});
    put_row("auipc", utype_word(OPC_AUIPC, 16, imm_v), 1, 1, 16, next_row_pc() + {imm_v, 12'b0});
    // store then load the same word
    put_row("addi_base", itype_word(OPC_OP_IMM, F3_ADD, 17, 0, DATA_BASE), 1, 1, 17,
            sext12(DATA_BASE));
    put_row("sw", stype_word(17, 7, 12'd8), 1, 0, 0, 32'h0);
    put_row("lw", itype_word(OPC_LOAD, F3_WORD, 18, 17, 12'd8), 1, 1, 18, xr[7]);
    // control flow where skipped rows must never retire
    put_row("jal", jtype_word(19, 21'd8), 1, 1, 19, next_row_pc() + 32'd4);
    put_row("skip_jal", itype_word(OPC_OP_IMM, F3_ADD, 20, 0, 12'd1), 0, 1, 20, 32'd1);
    put_row("beq_taken", btype_word(F3_BEQ, 1, 1, 13'd8), 1, 0, 0, 32'h0);
    put_row("skip_beq", itype_word(OPC_OP_IMM, F3_ADD, 20, 0, 12'd2), 0, 1, 20, 32'd2);
    put_row("bne_not_taken", btype_word(F3_BNE, 1, 1, 13'd8), 1, 0, 0, 32'h0);
    put_row("bne_taken", btype_word(F3_BNE, 1, 2, 13'd8), 1, 0, 0, 32'h0);
    put_row("skip_bne", itype_word(OPC_OP_IMM, F3_ADD, 20, 0, 12'd3), 0, 1, 20, 32'd3);
    put_row("add_link_load", rtype_word(F7_BASE, F3_ADD, 21, 18, 19), 1, 1, 21, xr[18] + xr[19]);
    put_row("ebreak", EBREAK_WORD, 0, 0, 0, 32'h0);
    put_row("after_ebreak", itype_word(OPC_OP_IMM, F3_ADD, 22, 0, 12'd4), 0, 1, 22, 32'd4);
  endtask

  task automatic build_illegal_program();
    logic [11:0] imm_a;
    clear_program();
    seed  = xorshift(seed);
    imm_a = seed[11:0];
    put_row("addi", itype_word(OPC_OP_IMM, F3_ADD, 1, 0, imm_a), 1, 1, 1, sext12(imm_a));
    put_row("ori", itype_word(OPC_OP_IMM, F3_OR, 2, 1, 12'h0f0), 1, 1, 2, xr[1] | 32'h0f0);
    // slli is outside the supported set
    put_row("slli_illegal", itype_word(OPC_OP_IMM, 3'b001, 3, 1, 12'd2), 0, 1, 3, 32'h0);
    put_row("after_illegal", itype_word(OPC_OP_IMM, F3_ADD, 4, 0, 12'd6), 0, 1, 4, 32'd6);
  endtask

  // fill pattern first and the program words on top
  task automatic load_memory();
    logic [31:0] a;
    for (int i = 0; i < MEM_WORDS; i++) begin
      a      = i;
      mem[i] = {a[15:0] ^ 16'h5a5a, ~a[15:0]};
    end
    for (int i = 0; i < n_rows; i++) begin
      mem[(RESET_PC >> 2) + i] = row_inst[i];
    end
  endtask

  task automatic send_expected();
    logic [31:0] pc;
    core_checker_i.clear_rows();
    for (int i = 0; i < n_rows; i++) begin
      pc = RESET_PC + 4 * i;
      if (row_retires[i]) begin
        core_checker_i.add_row(row_name[i], pc, row_rw[i], row_rd[i], row_value[i]);
      end
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    mem_rdata  = 32'h0;
    rd_pending = 1'b0;
    rd_index   = 0;
    tb_errors  = 0;
    seed       = SEED;
    // run 1 executes the full program up to ebreak
    build_main_program();
    load_memory();
    send_expected();
    apply_reset();
    core_checker_i.check_run(1'b0);
    if (mem[(DATA_BASE + 12'd8) >> 2] !== xr[7]) begin
      $display("FAILED sw_memory: expected %h, actual %h", xr[7], mem[(DATA_BASE + 12'd8) >> 2]);
      tb_errors++;
    end
    // run 2 resets again and stops on a bad word
    build_illegal_program();
    load_memory();
    send_expected();
    apply_reset();
    core_checker_i.check_run(1'b1);
    $display("errors: checker %0d, testbench %0d", core_checker_i.errors, tb_errors);
    if (core_checker_i.errors == 0 && tb_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
source/riscv_pkg.sv
source/bus_pkg.sv
source/decoder.sv
source/register_file.sv
source/alu.sv
source/sequencer.sv
source/load_store_unit.sv
source/mem_arbiter.sv
source/core_top.sv
tests/core_checker.sv
tests/core_tb.sv
